// File: verilog/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// datapath width of the integer slice
`define XLEN 32

// debug program counter width
`define PC_W 12

// architectural registers, x0 included
`define NREGS 32

`endif

// File: verilog/rv_isa_pkg.sv
package rv_isa_pkg;

	// major opcodes handled by this slice
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111
	} opcode_t;

	// funct3 field of the integer arithmetic group
	typedef enum logic [2:0] {
		F3_ADD_SUB = 3'b000,
		F3_SLL     = 3'b001,
		F3_SLT     = 3'b010,
		F3_SLTU    = 3'b011,
		F3_XOR     = 3'b100,
		F3_SRL_SRA = 3'b101,
		F3_OR      = 3'b110,
		F3_AND     = 3'b111
	} funct3_t;

	// instruction bit that selects SUB and SRA (funct7[5])
	localparam int unsigned F7_ALT_BIT = 30;

	// operations the execute stage knows about
	typedef enum logic [3:0] {
		ADD    = 4'd0,
		SUB    = 4'd1,
		SLL    = 4'd2,
		SLT    = 4'd3,
		SLTU   = 4'd4,
		XOR    = 4'd5,
		SRL    = 4'd6,
		SRA    = 4'd7,
		OR     = 4'd8,
		AND    = 4'd9,
		PASS_B = 4'd10
	} alu_op_t;

endpackage

// File: verilog/pipe_pkg.sv
`include "core_macros.svh"

package pipe_pkg;
	import rv_isa_pkg::*;

	// decode to execute payload
	typedef struct packed {
		logic             valid;
		logic [`PC_W-1:0] pc;
		logic [`XLEN-1:0] op_a;
		// immediate already muxed in for OP_IMM and LUI
		logic [`XLEN-1:0] op_b;
		logic [4:0]       rd;
		alu_op_t          alu_op;
		logic             wr_en;
		// source indices, kept for debug
		logic [4:0]       rs1;
		logic [4:0]       rs2;
	} id_exe_t;

	// execute to writeback payload
	typedef struct packed {
		logic             valid;
		logic [`PC_W-1:0] pc;
		logic [4:0]       rd;
		logic             wr_en;
		logic [`XLEN-1:0] result;
	} exe_wb_t;

endpackage

// File: verilog/reg_file.sv
`include "core_macros.svh"

module reg_file (
	input  logic             clk,
	input  logic             nrst,
	input  logic [4:0]       raddr1,
	input  logic [4:0]       raddr2,
	output logic [`XLEN-1:0] rdata1,
	output logic [`XLEN-1:0] rdata2,
	input  logic             we,
	input  logic [4:0]       waddr,
	input  logic [`XLEN-1:0] wdata
);

	// x0 has no storage
	logic [`XLEN-1:0] regs [1:`NREGS-1];

	// zero for x0, new data when the same register is written this cycle
	function automatic logic [`XLEN-1:0] read_port(input logic [4:0] addr);
		if (addr == 5'd0)
			return '0;
		else if (we && addr == waddr)
			return wdata;
		else
			return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (!nrst) begin
			for (int i = 1; i < `NREGS; i++)
				regs[i] <= '0;
		end else if (we && waddr != 5'd0) begin
			regs[waddr] <= wdata;
		end
	end

	always_comb begin
		rdata1 = read_port(raddr1);
		rdata2 = read_port(raddr2);
	end

endmodule

// File: verilog/pipe_reg.sv
module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     nrst,
	input  logic     flush,
	input  logic     en,
	input  payload_t d,
	output payload_t q
);

	// flush beats en; an all-zero payload is a bubble
	always_ff @(posedge clk) begin
		if (!nrst || flush) begin
			q <= '0;
		end else if (en) begin
			q <= d;
		end
	end

endmodule

// File: verilog/inst_decoder.sv
`include "core_macros.svh"

module inst_decoder
	import rv_isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic             in_valid,
	input  logic [31:0]      in_inst,
	input  logic [`PC_W-1:0] in_pc,
	output logic [4:0]       rf_raddr1,
	output logic [4:0]       rf_raddr2,
	input  logic [`XLEN-1:0] rf_rdata1,
	input  logic [`XLEN-1:0] rf_rdata2,
	input  exe_wb_t          exe_fwd,
	output id_exe_t          id_out
);

	logic [4:0]       rs1;
	logic [4:0]       rs2;
	logic [4:0]       rd;
	funct3_t          f3;
	logic             alt;
	logic [`XLEN-1:0] imm_i;
	logic [`XLEN-1:0] imm_u;
	logic [`XLEN-1:0] imm;
	logic [`XLEN-1:0] fwd_a;
	logic [`XLEN-1:0] fwd_b;
	logic             fwd_ok;
	alu_op_t          alu_op;
	logic             wr_en;
	logic             use_imm;
	logic             use_rs1;
	logic             use_rs2;

	// funct3 to alu op, SUB only exists in register form
	function automatic alu_op_t map_alu(input funct3_t f, input logic sel_alt, input logic is_reg);
		case (f)
			F3_ADD_SUB: return (sel_alt && is_reg) ? SUB : ADD;
			F3_SLL:     return SLL;
			F3_SLT:     return SLT;
			F3_SLTU:    return SLTU;
			F3_XOR:     return XOR;
			F3_SRL_SRA: return sel_alt ? SRA : SRL;
			F3_OR:      return OR;
			default:    return AND;
		endcase
	endfunction

	assign rd  = in_inst[11:7];
	assign rs1 = in_inst[19:15];
	assign rs2 = in_inst[24:20];
	assign f3  = funct3_t'(in_inst[14:12]);
	assign alt = in_inst[F7_ALT_BIT];

	assign imm_i = {{(`XLEN-12){in_inst[31]}}, in_inst[31:20]};
	assign imm_u = {in_inst[31:12], 12'b0};

	assign rf_raddr1 = rs1;
	assign rf_raddr2 = rs2;

	always_comb begin
		alu_op  = ADD;
		wr_en   = 1'b0;
		use_imm = 1'b0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		imm     = imm_i;
		case (opcode_t'(in_inst[6:0]))
			OP: begin
				alu_op  = map_alu(f3, alt, 1'b1);
				wr_en   = 1'b1;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
			end
			OP_IMM: begin
				alu_op  = map_alu(f3, alt, 1'b0);
				wr_en   = 1'b1;
				use_rs1 = 1'b1;
				use_imm = 1'b1;
			end
			LUI: begin
				alu_op  = PASS_B;
				wr_en   = 1'b1;
				use_imm = 1'b1;
				imm     = imm_u;
			end
			// unknown opcode still retires, but writes nothing
			default: ;
		endcase
	end

	// result one ahead is still in EXE and not yet in the register file
	assign fwd_ok = exe_fwd.valid && exe_fwd.wr_en && (exe_fwd.rd != 5'd0);
	assign fwd_a  = (fwd_ok && exe_fwd.rd == rs1) ? exe_fwd.result : rf_rdata1;
	assign fwd_b  = (fwd_ok && exe_fwd.rd == rs2) ? exe_fwd.result : rf_rdata2;

	always_comb begin
		id_out        = '0;
		id_out.valid  = in_valid;
		id_out.pc     = in_pc;
		id_out.op_a   = use_rs1 ? fwd_a : '0;
		id_out.op_b   = use_imm ? imm : fwd_b;
		id_out.rd     = rd;
		id_out.alu_op = alu_op;
		id_out.wr_en  = wr_en;
		id_out.rs1    = use_rs1 ? rs1 : 5'd0;
		id_out.rs2    = use_rs2 ? rs2 : 5'd0;
	end

endmodule

// File: verilog/exe_alu.sv
`include "core_macros.svh"

module exe_alu
	import rv_isa_pkg::*;
	import pipe_pkg::*;
(
	input  id_exe_t exe_in,
	output exe_wb_t exe_out
);

	logic [`XLEN-1:0] a;
	logic [`XLEN-1:0] b;
	logic [4:0]       shamt;
	logic [`XLEN-1:0] result;

	assign a     = exe_in.op_a;
	assign b     = exe_in.op_b;
	// only the low five bits count as shift amount
	assign shamt = b[4:0];

	always_comb begin
		case (exe_in.alu_op)
			ADD:     result = a + b;
			SUB:     result = a - b;
			SLL:     result = a << shamt;
			SLT:     result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			SLTU:    result = {{(`XLEN-1){1'b0}}, a < b};
			XOR:     result = a ^ b;
			SRL:     result = a >> shamt;
			SRA:     result = $unsigned($signed(a) >>> shamt);
			OR:      result = a | b;
			AND:     result = a & b;
			PASS_B:  result = b;
			default: result = '0;
		endcase
	end

	// also feeds the decoder as forwarding source
	always_comb begin
		exe_out        = '0;
		exe_out.valid  = exe_in.valid;
		exe_out.pc     = exe_in.pc;
		exe_out.rd     = exe_in.rd;
		exe_out.wr_en  = exe_in.wr_en;
		exe_out.result = result;
	end

endmodule

// File: verilog/exe_slice_top.sv
`include "core_macros.svh"

module exe_slice_top
	import pipe_pkg::*;
(
	input  logic             clk,
	input  logic             nrst,
	input  logic             en,
	input  logic             flush,
	input  logic             in_valid,
	input  logic [31:0]      in_inst,
	input  logic [`PC_W-1:0] in_pc,
	output logic             wb_valid,
	output logic [4:0]       wb_rd,
	output logic [`XLEN-1:0] wb_data,
	output logic [`PC_W-1:0] wb_pc
);

	id_exe_t          id_d;
	id_exe_t          id_q;
	exe_wb_t          exe_d;
	exe_wb_t          exe_q;
	logic [4:0]       rf_raddr1;
	logic [4:0]       rf_raddr2;
	logic [`XLEN-1:0] rf_rdata1;
	logic [`XLEN-1:0] rf_rdata2;
	logic             wb_commit;

	// retire only on an enabled edge, so a stall never reports twice
	assign wb_commit = exe_q.valid && exe_q.wr_en && en;

	inst_decoder u_decoder (
		.in_valid  (in_valid),
		.in_inst   (in_inst),
		.in_pc     (in_pc),
		.rf_raddr1 (rf_raddr1),
		.rf_raddr2 (rf_raddr2),
		.rf_rdata1 (rf_rdata1),
		.rf_rdata2 (rf_rdata2),
		.exe_fwd   (exe_d),
		.id_out    (id_d)
	);

	reg_file u_reg_file (
		.clk    (clk),
		.nrst   (nrst),
		.raddr1 (rf_raddr1),
		.raddr2 (rf_raddr2),
		.rdata1 (rf_rdata1),
		.rdata2 (rf_rdata2),
		.we     (wb_commit),
		.waddr  (exe_q.rd),
		.wdata  (exe_q.result)
	);

	pipe_reg #(.payload_t(id_exe_t)) u_id_exe (
		.clk   (clk),
		.nrst  (nrst),
		.flush (flush),
		.en    (en),
		.d     (id_d),
		.q     (id_q)
	);

	exe_alu u_alu (
		.exe_in  (id_q),
		.exe_out (exe_d)
	);

	// nothing upstream of writeback is ever squashed here
	pipe_reg #(.payload_t(exe_wb_t)) u_exe_wb (
		.clk   (clk),
		.nrst  (nrst),
		.flush (1'b0),
		.en    (en),
		.d     (exe_d),
		.q     (exe_q)
	);

	assign wb_valid = wb_commit;
	assign wb_rd    = exe_q.rd;
	assign wb_data  = exe_q.result;
	assign wb_pc    = exe_q.pc;

endmodule

// File: verification/tb_exe_slice.sv
`include "core_macros.svh"

module tb_exe_slice
	import rv_isa_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int          NUM_INST       = 2000;
	localparam int          TIMEOUT_CYCLES = 8 * NUM_INST + 100;
	localparam logic [31:0] SEED           = 32'h8a82;

	// instruction classes the stimulus draws from
	localparam int K_OP  = 0;
	localparam int K_IMM = 1;
	localparam int K_LUI = 2;
	localparam int K_BAD = 3;

	typedef struct packed {
		logic [4:0]       rd;
		logic [`XLEN-1:0] data;
		logic [`PC_W-1:0] pc;
	} wb_exp_t;

	logic             clk;
	logic             nrst;
	logic             en;
	logic             flush;
	logic             in_valid;
	logic [31:0]      in_inst;
	logic [`PC_W-1:0] in_pc;
	logic             wb_valid;
	logic [4:0]       wb_rd;
	logic [`XLEN-1:0] wb_data;
	logic [`PC_W-1:0] wb_pc;

	// fields of the instruction currently on in_inst
	int               cur_kind;
	logic [2:0]       cur_f3;
	logic             cur_alt;
	logic [4:0]       cur_rd;
	logic [4:0]       cur_rs1;
	logic [4:0]       cur_rs2;
	logic [11:0]      cur_imm12;
	logic [19:0]      cur_imm20;
	logic [6:0]       cur_bad_op;

	logic [`XLEN-1:0] model_regs [0:`NREGS-1];
	wb_exp_t          exp_q [$];
	logic [31:0]      rng_state;
	int               accepted_cnt;
	int               cycle_cnt;
	int               mismatch_cnt;
	int               fail_cnt;

	exe_slice_top UUT (
		.clk      (clk),
		.nrst     (nrst),
		.en       (en),
		.flush    (flush),
		.in_valid (in_valid),
		.in_inst  (in_inst),
		.in_pc    (in_pc),
		.wb_valid (wb_valid),
		.wb_rd    (wb_rd),
		.wb_data  (wb_data),
		.wb_pc    (wb_pc)
	);

	always #2 clk = ~clk;

	// low LCG bits repeat quickly and are dropped
	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state >> 8;
	endfunction

	task automatic pick_instruction();
		logic [31:0] r;
		logic [31:0] r2;
		r  = next_rand();
		r2 = next_rand();
		// x0..x7 only, so dependencies are dense
		cur_rd     = {2'b00, r[2:0]};
		cur_rs1    = {2'b00, r[5:3]};
		cur_rs2    = {2'b00, r[8:6]};
		cur_f3     = r[11:9];
		cur_alt    = r[12] && (r[11:9] == 3'd0 || r[11:9] == 3'd5);
		cur_imm20  = r2[19:0];
		cur_imm12  = r2[31:20];
		cur_bad_op = r[17] ? 7'b0000011 : 7'b1100011;
		case (r[16:13])
			4'd0:                             cur_kind = K_BAD;
			4'd1, 4'd2, 4'd3:                 cur_kind = K_LUI;
			4'd4, 4'd5, 4'd6, 4'd7, 4'd8, 4'd9: cur_kind = K_IMM;
			default:                          cur_kind = K_OP;
		endcase
		// shift immediates carry funct7 in imm[11:5]
		if (cur_kind == K_IMM && cur_f3 == 3'd1)
			cur_imm12 = {7'b0, r2[4:0]};
		else if (cur_kind == K_IMM && cur_f3 == 3'd5)
			cur_imm12 = {1'b0, cur_alt, 5'b0, r2[4:0]};
	endtask

	function automatic logic [31:0] encode_inst();
		case (cur_kind)
			K_OP:    return {1'b0, cur_alt, 5'b0, cur_rs2, cur_rs1, cur_f3, cur_rd, OP};
			K_IMM:   return {cur_imm12, cur_rs1, cur_f3, cur_rd, OP_IMM};
			K_LUI:   return {cur_imm20, cur_rd, LUI};
			default: return {cur_imm12, cur_rs1, cur_f3, cur_rd, cur_bad_op};
		endcase
	endfunction

	// RV32I arithmetic on the model's in-order registers
	function automatic logic [`XLEN-1:0] model_result();
		logic [`XLEN-1:0]        a;
		logic [`XLEN-1:0]        b;
		logic signed [`XLEN-1:0] sa;
		logic [`XLEN-1:0]        sra;
		a = model_regs[cur_rs1];
		if (cur_kind == K_OP)
			b = model_regs[cur_rs2];
		else
			b = {{(`XLEN-12){cur_imm12[11]}}, cur_imm12};
		sa  = a;
		sra = sa >>> b[4:0];
		if (cur_kind == K_LUI)
			return {cur_imm20, 12'b0};
		case (cur_f3)
			3'd0: return (cur_kind == K_OP && cur_alt) ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? `XLEN'(1) : `XLEN'(0);
			3'd3: return (a < b) ? `XLEN'(1) : `XLEN'(0);
			3'd4: return a ^ b;
			3'd5: begin
				if (cur_alt)
					return sra;
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	always @(posedge clk) begin
		wb_exp_t     item;
		logic [31:0] r;
		logic        next_en;
		if (nrst) begin
			// inputs as the DUT samples them at this edge
			if (in_valid && en && !flush) begin
				accepted_cnt++;
				if (cur_kind != K_BAD) begin
					item.rd   = cur_rd;
					item.data = model_result();
					item.pc   = in_pc;
					exp_q.push_back(item);
					if (cur_rd != 5'd0)
						model_regs[cur_rd] = item.data;
				end
			end
			r = next_rand();
			if (accepted_cnt >= NUM_INST) begin
				// drain the pipeline
				in_valid <= 1'b0;
				en       <= 1'b1;
				flush    <= 1'b0;
			end else begin
				next_en = (r % 6) != 0;
				en      <= next_en;
				// flush with en low would also clear the frozen EXE stage
				flush   <= next_en && ((r / 6) % 10 == 0);
				// a stalled instruction stays on the inputs
				if (!(in_valid && !en && !flush)) begin
					pick_instruction();
					in_valid <= ((r / 60) % 8) != 0;
					in_inst  <= encode_inst();
					in_pc    <= in_pc + `PC_W'(4);
				end
			end
		end
	end

	always @(negedge clk) begin
		wb_exp_t want;
		if (!nrst) begin
			assert (!wb_valid) else begin
				$display("writeback reported while reset is asserted");
				fail_cnt++;
			end
		end else if (wb_valid) begin
			assert (exp_q.size() > 0) else begin
				$display("writeback at pc %h with no instruction pending", wb_pc);
				fail_cnt++;
			end
			if (exp_q.size() > 0) begin
				want = exp_q.pop_front();
				assert (wb_rd == want.rd) else begin
					$display("MISMATCH wb_rd: got %h expected %h", wb_rd, want.rd);
					mismatch_cnt++;
				end
				assert (wb_data == want.data) else begin
					$display("MISMATCH wb_data: got %h expected %h (pc %h)",
						wb_data, want.data, want.pc);
					mismatch_cnt++;
				end
				assert (wb_pc == want.pc) else begin
					$display("MISMATCH wb_pc: got %h expected %h", wb_pc, want.pc);
					mismatch_cnt++;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles: %0d of %0d accepted, %0d writebacks pending",
				cycle_cnt, accepted_cnt, NUM_INST, exp_q.size());
			fail_cnt++;
			$display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
			$display("Done: errors found");
			$finish;
		end
	end

	initial begin
		clk          = 1'b0;
		nrst         = 1'b0;
		en           = 1'b0;
		flush        = 1'b0;
		in_valid     = 1'b0;
		in_pc        = '0;
		rng_state    = SEED;
		accepted_cnt = 0;
		cycle_cnt    = 0;
		mismatch_cnt = 0;
		fail_cnt     = 0;
		// a writing LUI to x1 waits on the inputs through reset
		cur_kind     = K_LUI;
		cur_f3       = '0;
		cur_alt      = 1'b0;
		cur_rd       = 5'd1;
		cur_rs1      = '0;
		cur_rs2      = '0;
		cur_imm12    = '0;
		cur_imm20    = 20'h5a5a5;
		cur_bad_op   = '0;
		in_inst      = encode_inst();
		for (int i = 0; i < `NREGS; i++)
			model_regs[i] = '0;
		@(posedge clk);
		// pipeline enabled during reset, only reset keeps it empty
		en       <= 1'b1;
		in_valid <= 1'b1;
		repeat (4) @(posedge clk);
		nrst <= 1'b1;
		while (!(accepted_cnt == NUM_INST && exp_q.size() == 0))
			@(posedge clk);
		// idle a while so a stray writeback would show
		repeat (10) @(posedge clk);
		$display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
		if (mismatch_cnt + fail_cnt == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// File: src.f
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/pipe_pkg.sv
verilog/reg_file.sv
verilog/pipe_reg.sv
verilog/inst_decoder.sv
verilog/exe_alu.sv
verilog/exe_slice_top.sv
verification/tb_exe_slice.sv

// File: Bender.yml
package:
  name: exe_slice

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv_isa_pkg.sv
      - verilog/pipe_pkg.sv
      - verilog/reg_file.sv
      - verilog/pipe_reg.sv
      - verilog/inst_decoder.sv
      - verilog/exe_alu.sv
      - verilog/exe_slice_top.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - verification/tb_exe_slice.sv
